// File: Makefile
# Verilator build and run for the memory card testbench

VERILATOR ?= verilator
TOP       := tb_card_mem
FILELIST  := verilog.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q '^Result: PASSED$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bank_if.sv
////////////////////
// Bank request interface
// Decoder to bank request, bank to collector read data
////////////////////

`timescale 1ns/1ps

interface bank_if import mem_card_pkg::*; ();

   // Request side, registered in the decoder
   logic                 en;              // One-cycle request strobe
   bus_op_e              op;              // Read or write, valid with en
   logic [BANK_AW-1:0]   addr;            // Word offset in the bank
   logic [DATA_W-1:0]    wdata;           // Write data

   // Return side, registered in the bank
   logic [DATA_W-1:0]    rdata;           // Read word
   logic                 rvalid;          // rdata valid for one cycle

   // Decoder drives the request
   modport dec (
      output en, op, addr, wdata
   );

   // Bank takes the request and returns data
   modport bank (
      input  en, op, addr, wdata,
      output rdata, rvalid
   );

   // Collector only sees the return side
   modport col (
      input rdata, rvalid
   );

endinterface

// File: card_mem.sv
////////////////////
// Memory card top level
// Decoder, four bank windows and the read collector on backplane strobes
////////////////////

`timescale 1ns/1ps

module card_mem import mem_card_pkg::*; (
   input  logic                clk1,      // Card clock
   input  logic                rst_n,
   input  logic                nmem,      // Memory space transfer
   input  logic                nr,        // Read strobe
   input  logic                nw,        // Write strobe
   input  logic [ADDR_W-1:0]   ab,        // 24-bit address bus
   input  logic [DATA_W-1:0]   db_wdata,  // Write half of the data bus
   input  logic                wp,        // ROM write protect
   output logic [DATA_W-1:0]   db_rdata,  // Read half of the data bus
   output logic                db_oe      // Read data driven
);

   ////////////////////
   // Bank links
   ////////////////////

   // One link per window, RAM in 0 to 2, ROM in 3
   bank_if banks [NUM_BANKS] ();

   ////////////////////
   // Address decode
   ////////////////////

   mem_decoder u_dec (
      .clk1     (clk1),
      .rst_n    (rst_n),
      .nmem     (nmem),
      .nr       (nr),
      .nw       (nw),
      .ab       (ab),
      .db_wdata (db_wdata),
      .wp       (wp),
      .banks    (banks)
   );

   ////////////////////
   // Memory banks
   ////////////////////

   // ROM window is an ordinary bank, protection lives in the decoder
   for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
      mem_bank u_bank (
         .clk1  (clk1),
         .rst_n (rst_n),
         .port  (banks[i])
      );
   end

   ////////////////////
   // Read return
   ////////////////////

   read_collector u_col (
      .clk1     (clk1),
      .rst_n    (rst_n),
      .banks    (banks),
      .db_rdata (db_rdata),
      .db_oe    (db_oe)              // READ_LATENCY after the sampling edge
   );

endmodule

// File: mem_bank.sv
////////////////////
// Memory bank
// 1024 x 16 synchronous store with a registered read port
////////////////////

`timescale 1ns/1ps

module mem_bank import mem_card_pkg::*; (
   input  logic   clk1,
   input  logic   rst_n,
   bank_if.bank   port
);

   ////////////////////
   // Storage
   ////////////////////

   logic [DATA_W-1:0]   mem [BANK_WORDS];  // Whole window, aliased by the decoder
   logic [DATA_W-1:0]   rdata_q;
   logic                rvalid_q;
   logic                do_wr;
   logic                do_rd;

   // Request qualifiers
   assign do_wr = port.en && (port.op == OP_WRITE);
   assign do_rd = port.en && (port.op == OP_READ);

   ////////////////////
   // Write and read, edge 2
   ////////////////////

   always_ff @(posedge clk1) begin
      if (do_wr) begin
         mem[port.addr] <= port.wdata;     // Visible to a read one cycle later
      end
   end

   always_ff @(posedge clk1) begin
      if (do_rd) begin
         rdata_q <= mem[port.addr];        // Held until the next read
      end
   end

   // Read data strobe
   always_ff @(posedge clk1 or negedge rst_n) begin
      if (!rst_n) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= do_rd;                // Single-cycle pulse per read
      end
   end

   ////////////////////
   // Return side
   ////////////////////

   assign port.rdata  = rdata_q;
   assign port.rvalid = rvalid_q;

   // A request always carries a real operation
   a_en_op: assert property (@(posedge clk1) disable iff (!rst_n)
      port.en |-> (port.op != OP_IDLE));

endmodule

// File: mem_card_pkg.sv
////////////////////
// Memory card package
// Address map, bank geometry and the decoded bus operation
////////////////////

package mem_card_pkg;

   ////////////////////
   // Bus widths
   ////////////////////

   localparam int DATA_W = 16;            // One bus word
   localparam int ADDR_W = 24;            // Full backplane address

   ////////////////////
   // Bank geometry
   ////////////////////

   localparam int BANK_AW    = 10;              // Word address bits per bank
   localparam int BANK_WORDS = 1 << BANK_AW;    // 1024 words per bank
   localparam int NUM_BANKS  = 4;               // Three RAM windows and one ROM

   // Bank index sits in ab[21:20]
   localparam int BANK_SEL_LSB = 20;
   localparam int BANK_SEL_W   = 2;

   // ab[23:22] must be zero for a mapped access
   localparam int MAP_LSB = BANK_SEL_LSB + BANK_SEL_W;

   localparam int ROM_BANK = 3;           // Write protected window

   // Sample edge to db_oe high
   // Decoder register, bank register and collector register
   localparam int READ_LATENCY = 3;

   ////////////////////
   // Decoded bus operation
   ////////////////////

   typedef enum logic [1:0] {
      OP_IDLE  = 2'b00,                   // No strobe, or nmem high
      OP_READ  = 2'b01,                   // nr low
      OP_WRITE = 2'b10                    // nw low
   } bus_op_e;

endpackage

// File: mem_decoder.sv
////////////////////
// Memory card address decoder
// Samples the bus strobes, picks a bank window and issues its request
////////////////////

`timescale 1ns/1ps

module mem_decoder import mem_card_pkg::*; (
   input  logic                clk1,
   input  logic                rst_n,
   input  logic                nmem,      // Memory space strobe, active low
   input  logic                nr,        // Read strobe, active low
   input  logic                nw,        // Write strobe, active low
   input  logic [ADDR_W-1:0]   ab,
   input  logic [DATA_W-1:0]   db_wdata,
   input  logic                wp,        // High protects the ROM window
   bank_if.dec                 banks [NUM_BANKS]
);

   ////////////////////
   // Bus sampling, edge 0
   ////////////////////

   bus_op_e               op_now;         // Strobes turned into an operation
   bus_op_e               op_s;
   logic [ADDR_W-1:0]     addr_s;
   logic [DATA_W-1:0]     wdata_s;
   logic                  wp_s;

   always_comb begin
      op_now = OP_IDLE;
      if (!nmem) begin
         if (!nr)      op_now = OP_READ;
         else if (!nw) op_now = OP_WRITE;
      end
   end

   always_ff @(posedge clk1 or negedge rst_n) begin
      if (!rst_n) op_s <= OP_IDLE;
      else        op_s <= op_now;
   end

   always_ff @(posedge clk1) begin        // Bus payload, qualified by op_s
      addr_s  <= ab;
      wdata_s <= db_wdata;
      wp_s    <= wp;                      // Protect level taken with the cycle
   end

   ////////////////////
   // Window decode
   ////////////////////

   logic [BANK_SEL_W-1:0] bank_idx;
   logic                  mapped;
   logic                  protect;        // Write to ROM while protected
   logic                  allow;
   logic [NUM_BANKS-1:0]  sel;
   logic [NUM_BANKS-1:0]  en_q;

   assign bank_idx = addr_s[BANK_SEL_LSB +: BANK_SEL_W];
   assign mapped   = (addr_s[ADDR_W-1:MAP_LSB] == '0);   // ab[23:22] both clear
   assign protect  = (op_s == OP_WRITE) && wp_s && (bank_idx == BANK_SEL_W'(ROM_BANK));
   assign allow    = (op_s != OP_IDLE) && mapped && !protect;

   ////////////////////
   // Per-bank request, edge 1
   ////////////////////

   always_ff @(posedge clk1 or negedge rst_n) begin
      if (!rst_n) en_q <= '0;
      else        en_q <= sel;            // At most one bit set
   end

   for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_req
      assign sel[i] = allow && (bank_idx == BANK_SEL_W'(i));

      always_ff @(posedge clk1) begin     // Only the addressed bank loads
         if (sel[i]) begin
            banks[i].op    <= op_s;
            banks[i].addr  <= addr_s[BANK_AW-1:0];   // ab[19:10] ignored, aliases
            banks[i].wdata <= wdata_s;
         end
      end

      assign banks[i].en = en_q[i];
   end

   // Backplane rule, the two strobes are never low together
   a_strobe_excl: assert property (@(posedge clk1) disable iff (!rst_n)
      !(!nr && !nw));

   // One bank request per sampled bus cycle
   a_one_en: assert property (@(posedge clk1) disable iff (!rst_n)
      $onehot0(en_q));

endmodule

// File: read_collector.sv
////////////////////
// Read collector
// Merges the bank returns onto db_rdata with its enable db_oe
////////////////////

`timescale 1ns/1ps

module read_collector import mem_card_pkg::*; (
   input  logic                clk1,
   input  logic                rst_n,
   bank_if.col                 banks [NUM_BANKS],
   output logic [DATA_W-1:0]   db_rdata,
   output logic                db_oe      // High for one cycle per read
);

   ////////////////////
   // Bank returns
   ////////////////////

   logic [NUM_BANKS-1:0]   rvalid_vec;
   logic [DATA_W-1:0]      rdata_arr [NUM_BANKS];
   logic [DATA_W-1:0]      sel_data;       // One-hot selected word
   logic                   any_valid;

   for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_ret
      assign rvalid_vec[i] = banks[i].rvalid;
      assign rdata_arr[i]  = banks[i].rdata;
   end

   // AND-OR mux, rvalid is one-hot or zero
   always_comb begin
      sel_data = '0;
      for (int i = 0; i < NUM_BANKS; i++) begin
         sel_data = sel_data | (rdata_arr[i] & {DATA_W{rvalid_vec[i]}});
      end
   end

   assign any_valid = |rvalid_vec;

   ////////////////////
   // Read bus, edge 3
   ////////////////////

   always_ff @(posedge clk1 or negedge rst_n) begin
      if (!rst_n) begin
         db_oe    <= 1'b0;
         db_rdata <= '0;
      end else begin
         db_oe <= any_valid;
         if (any_valid) begin
            db_rdata <= sel_data;          // Holds last word otherwise
         end
      end
   end

   // Pipeline issues one request per cycle, so returns never collide
   a_one_rvalid: assert property (@(posedge clk1) disable iff (!rst_n)
      $onehot0(rvalid_vec));

endmodule

// File: tb_card_mem.sv
////////////////////
// Memory card testbench
// Drives the backplane strobes and checks reads against a word model
////////////////////

`timescale 1ns/1ps

module tb_card_mem import mem_card_pkg::*; ();

   ////////////////////
   // Run limits
   ////////////////////

   localparam int SEED           = 86895;
   localparam int RESET_CYCLES   = 10;
   localparam int FILL_XFERS     = NUM_BANKS * BANK_WORDS;   // One write per word
   localparam int DIRECTED_XFERS = 100;                      // Tests 1 to 5, with drain
   localparam int RANDOM_XFERS   = 400;
   localparam int MARGIN         = 100;
   localparam int MAX_CYCLES     = RESET_CYCLES + FILL_XFERS + DIRECTED_XFERS
                                   + RANDOM_XFERS + MARGIN;

   ////////////////////
   // DUT signals
   ////////////////////

   logic                clk1 = 1'b0;
   logic                rst_n;
   logic                nmem;
   logic                nr;
   logic                nw;
   logic [ADDR_W-1:0]   ab;
   logic [DATA_W-1:0]   db_wdata;
   logic                wp;
   logic [DATA_W-1:0]   db_rdata;
   logic                db_oe;

   card_mem DUT (
      .clk1     (clk1),
      .rst_n    (rst_n),
      .nmem     (nmem),
      .nr       (nr),
      .nw       (nw),
      .ab       (ab),
      .db_wdata (db_wdata),
      .wp       (wp),
      .db_rdata (db_rdata),
      .db_oe    (db_oe)
   );

   always #4 clk1 = ~clk1;                // 8 ns card clock

   int  cyc = 0;                          // Rising edges seen
   always @(posedge clk1) cyc <= cyc + 1;

   ////////////////////
   // Reference model
   ////////////////////

   logic [DATA_W-1:0]   ref_mem [NUM_BANKS][BANK_WORDS];
   int                  q_cyc [$];        // Cycle at which the result shows
   bit                  q_has [$];        // Read data expected
   logic [DATA_W-1:0]   q_data [$];
   string               q_name [$];
   string               cur_test = "reset";
   bit                  checking = 1'b0;
   int                  n_err    = 0;     // Value mismatches
   int                  n_other  = 0;     // Timeouts
   int                  n_checks = 0;

   // Address from its fields, hi lands in ab[23:22]
   function automatic logic [ADDR_W-1:0] make_addr(input int bank, input int off,
                                                   input int alias_bits, input int hi);
      return {2'(hi), 2'(bank), 10'(alias_bits), 10'(off)};
   endfunction

   // Bit DATA_W set when a mapped read returns data
   function automatic logic [DATA_W:0] expected_read(input logic [ADDR_W-1:0] a);
      logic [BANK_SEL_W-1:0] b;
      logic [BANK_AW-1:0]    o;
      b = a[BANK_SEL_LSB +: BANK_SEL_W];
      o = a[BANK_AW-1:0];                 // ab[19:10] alias
      if (a[ADDR_W-1 -: 2] != 2'b00) return '0;
      return {1'b1, ref_mem[b][o]};
   endfunction

   function automatic void apply_write(input logic [ADDR_W-1:0] a,
                                       input logic [DATA_W-1:0] d, input logic wp_v);
      logic [BANK_SEL_W-1:0] b;
      b = a[BANK_SEL_LSB +: BANK_SEL_W];
      if (a[ADDR_W-1 -: 2] != 2'b00) return;             // Unmapped
      if (wp_v && int'(b) == ROM_BANK) return;            // Protected ROM
      ref_mem[b][a[BANK_AW-1:0]] = d;
   endfunction

   ////////////////////
   // Bus cycles, driven on the falling edge
   ////////////////////

   task automatic push_expect(input bit has, input logic [DATA_W-1:0] d);
      q_cyc.push_back(cyc + 1 + READ_LATENCY);           // Sampled at the next rise
      q_has.push_back(has);
      q_data.push_back(d);
      q_name.push_back(cur_test);
   endtask

   task automatic bus_read(input logic [ADDR_W-1:0] a);
      logic [DATA_W:0] e;
      e = expected_read(a);
      nmem = 1'b0;
      nr   = 1'b0;
      nw   = 1'b1;
      ab   = a;
      push_expect(e[DATA_W], e[DATA_W-1:0]);
      @(negedge clk1);
   endtask

   task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      nmem     = 1'b0;
      nr       = 1'b1;
      nw       = 1'b0;
      ab       = a;
      db_wdata = d;
      apply_write(a, d, wp);              // wp goes with the same cycle
      push_expect(1'b0, '0);              // Never any read data
      @(negedge clk1);
   endtask

   task automatic bus_idle();
      nmem = 1'b1;
      nr   = 1'b1;
      nw   = 1'b1;
      @(negedge clk1);
   endtask

   task automatic finish_run(input bit timed_out);
      $display("Errors: value=%0d other=%0d (checks=%0d)", n_err, n_other, n_checks);
      if (timed_out || n_err != 0 || n_other != 0) begin
         $display("Result: FAILED");
      end else begin
         $display("Result: PASSED");
      end
      $finish;
   endtask

   ////////////////////
   // Compare, once per cycle on the falling edge
   ////////////////////

   logic [DATA_W-1:0] last_data = '0;     // db_rdata after reset

   always @(negedge clk1) begin : compare
      bit                has;
      logic [DATA_W-1:0] exp;
      string             name;
      has  = 1'b0;
      exp  = last_data;
      name = cur_test;
      if (checking) begin
         if (q_cyc.size() > 0 && q_cyc[0] == cyc) begin
            void'(q_cyc.pop_front());
            has  = q_has.pop_front();
            name = q_name.pop_front();
            if (has) exp = q_data.pop_front();
            else void'(q_data.pop_front());
         end
         n_checks++;
         if (has) begin
            assert (db_oe === 1'b1) else begin
               n_err++;
               $display("FAIL %s: db_oe expected 1 actual %b", name, db_oe);
            end
            last_data = exp;
         end else begin
            assert (db_oe === 1'b0) else begin
               n_err++;
               $display("FAIL %s: db_oe expected 0 actual %b", name, db_oe);
            end
         end
         assert (db_rdata === exp) else begin   // Held when no data returns
            n_err++;
            $display("FAIL %s: db_rdata expected %h actual %h", name, exp, db_rdata);
         end
      end
   end

   // Cycle limit
   initial begin
      while (cyc < MAX_CYCLES) @(posedge clk1);
      n_other++;
      $display("Timeout: run still busy after %0d cycles", MAX_CYCLES);
      finish_run(1'b1);
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin
      int                ram_offs [4];
      logic [ADDR_W-1:0] a;
      int                kind;
      int                off;
      void'($urandom(SEED));
      ram_offs = '{0, 1, 517, 1023};
      rst_n    = 1'b0;
      nmem     = 1'b1;
      nr       = 1'b1;
      nw       = 1'b1;
      ab       = '0;
      db_wdata = '0;
      wp       = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk1);
      @(negedge clk1);
      rst_n    = 1'b1;
      checking = 1'b1;

      // 1. Quiet bus after reset
      cur_test = "reset_idle";
      assert (db_oe === 1'b0) else begin
         n_err++;
         $display("FAIL %s: db_oe expected 0 actual %b", cur_test, db_oe);
      end
      repeat (8) bus_idle();

      // Every word gets a known value, ROM loaded with wp low
      cur_test = "fill";
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int o = 0; o < BANK_WORDS; o++) begin
            bus_write(make_addr(b, o, 0, 0), 16'(b * BANK_WORDS + o) ^ 16'hC3A5);
         end
      end

      // 2. RAM banks, direct and aliased reads
      for (int b = 0; b < ROM_BANK; b++) begin
         cur_test = "ram_rw";
         for (int k = 0; k < 4; k++) bus_write(make_addr(b, ram_offs[k], 0, 0), 16'($urandom));
         for (int k = 0; k < 4; k++) begin
            cur_test = "ram_rw";
            bus_read(make_addr(b, ram_offs[k], 0, 0));
            cur_test = "ram_alias";
            bus_read(make_addr(b, ram_offs[k], $urandom_range(1023, 1), 0));
         end
      end

      // 3. ROM window, load then protect
      cur_test = "rom_load";
      for (int k = 0; k < 4; k++) begin
         bus_write(make_addr(ROM_BANK, ram_offs[k], 0, 0), 16'($urandom));
      end
      for (int k = 0; k < 4; k++) bus_read(make_addr(ROM_BANK, ram_offs[k], 0, 0));
      cur_test = "rom_protect";
      wp       = 1'b1;
      for (int k = 0; k < 4; k++) begin
         bus_write(make_addr(ROM_BANK, ram_offs[k], 0, 0), 16'($urandom));
      end
      for (int k = 0; k < 4; k++) bus_read(make_addr(ROM_BANK, ram_offs[k], 0, 0));
      wp       = 1'b0;

      // 4. ab[23:22] nonzero, nothing stored and nothing returned
      cur_test = "unmapped";
      for (int h = 1; h < 4; h++) begin
         bus_write(make_addr(1, 77, 0, h), 16'hDEAD);
         bus_read(make_addr(1, 77, 0, h));
      end
      bus_read(make_addr(1, 77, 0, 0));   // Mapped twin keeps its word

      // 5. Back to back reads and read after write
      cur_test = "pipeline";
      for (int i = 0; i < 12; i++) begin
         bus_read(make_addr(i % NUM_BANKS, $urandom_range(1023, 0), 0, 0));
      end
      cur_test = "read_after_write";
      for (int b = 0; b < NUM_BANKS; b++) begin
         a = make_addr(b, 300 + b, 0, 0);
         bus_write(a, 16'($urandom));
         bus_read(a);
      end

      // 6. Random traffic
      cur_test = "random";
      for (int i = 0; i < RANDOM_XFERS; i++) begin
         kind = $urandom_range(9, 0);
         if ($urandom_range(7, 0) == 0) wp = ~wp;
         off  = ($urandom_range(1, 0) == 1) ? $urandom_range(15, 0) : $urandom_range(1023, 0);
         a    = make_addr($urandom_range(3, 0), off, $urandom_range(1023, 0),
                          ($urandom_range(7, 0) == 0) ? $urandom_range(3, 1) : 0);
         if (kind < 2)      bus_idle();
         else if (kind < 6) bus_read(a);
         else               bus_write(a, 16'($urandom));
      end

      // Drain the read pipeline
      while (q_cyc.size() > 0) bus_idle();
      finish_run(1'b0);
   end

endmodule

// File: verilog.f
mem_card_pkg.sv
bank_if.sv
mem_decoder.sv
mem_bank.sv
read_collector.sv
card_mem.sv
tb_card_mem.sv
